// File: Bender.yml
package:
  name: axi_mem_slave

sources:
  # shared package first
  - src/mem_pkg.sv
  - src/line_store.sv
  - src/wr_channel.sv
  - src/rd_channel.sv
  - src/axi_mem_slave.sv

  # testbench with the bound checker
  - target: test
    files:
      - bench/axi_mem_assertions.sv
      - bench/axi_mem_tb.sv

// File: bench/axi_mem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_assertions (
  input wire logic           clk,
  input wire logic           rst,
  input wire logic           awvalid,
  input wire logic           awready,
  input wire mem_pkg::len_t  awlen,
  input wire logic           wvalid,
  input wire logic           wready,
  input wire logic           wlast,
  input wire logic           arready,
  input wire logic           rvalid,
  input wire logic           rready,
  input wire mem_pkg::data_t rdata,
  input wire logic           rlast
);

  int            fail_count = 0;  // read by the testbench at the end
  mem_pkg::len_t exp_len;
  mem_pkg::len_t beat_cnt;

  // own beat count, independent of the write channel
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (awvalid && awready) begin
      exp_len  <= awlen;
      beat_cnt <= '0;
    end else if (wvalid && wready) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  wlast_on_final_beat: assert property (@(posedge clk) disable iff (rst)
    (wvalid && wready) |-> (wlast == (beat_cnt == exp_len)))
    else begin
      fail_count++;
      $error("wlast does not match the burst length");
    end

  r_stable_when_stalled: assert property (@(posedge clk) disable iff (rst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rlast)))
    else begin
      fail_count++;
      $error("r channel changed during a stall");
    end

  aw_w_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(awready && wready))
    else begin
      fail_count++;
      $error("awready and wready high together");
    end

  // reset values visible on the cycle after a reset edge
  ready_reset_values: assert property (@(posedge clk)
    rst |=> (awready && !wready && arready && !rvalid && !rlast))
    else begin
      fail_count++;
      $error("wrong handshake outputs after reset");
    end

endmodule

bind axi_mem_slave axi_mem_assertions u_checks (.*);

`default_nettype wire

// File: bench/axi_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_tb;

  logic           clk;
  logic           rst;
  logic           awvalid;
  logic           awready;
  mem_pkg::addr_t awaddr;
  mem_pkg::len_t  awlen;
  logic           wvalid;
  logic           wready;
  mem_pkg::data_t wdata;
  mem_pkg::strb_t wstrb;
  logic           wlast;
  logic           arvalid;
  logic           arready;
  mem_pkg::addr_t araddr;
  mem_pkg::len_t  arlen;
  logic           rvalid;
  logic           rready;
  mem_pkg::data_t rdata;
  logic           rlast;

  integer seed;
  int     n_checks;
  int     n_errors;

  // expected memory, one entry per byte
  logic [7:0] ref_mem [mem_pkg::DEPTH_BEATS * mem_pkg::STRB_W];

  axi_mem_slave UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic mem_pkg::data_t random_data();
    mem_pkg::data_t d;
    for (int i = 0; i < mem_pkg::DATA_W / 32; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
    return d;
  endfunction

  // random upper bits, beat index in the middle, low bits aligned
  function automatic mem_pkg::addr_t make_addr(input mem_pkg::idx_t base);
    mem_pkg::addr_t a;
    a = $random(seed);
    a[mem_pkg::BEAT_SHIFT +: mem_pkg::IDX_W] = base;
    a[mem_pkg::BEAT_SHIFT-1:0] = '0;
    return a;
  endfunction

  task automatic ref_write(input mem_pkg::idx_t idx, input mem_pkg::data_t d,
                           input mem_pkg::strb_t s);
    for (int i = 0; i < mem_pkg::STRB_W; i++) begin
      if (s[i]) ref_mem[int'(idx) * mem_pkg::STRB_W + i] = d[i*8 +: 8];
    end
  endtask

  function automatic mem_pkg::data_t ref_beat(input mem_pkg::idx_t idx);
    mem_pkg::data_t d;
    for (int i = 0; i < mem_pkg::STRB_W; i++) begin
      d[i*8 +: 8] = ref_mem[int'(idx) * mem_pkg::STRB_W + i];
    end
    return d;
  endfunction

  task automatic check_data(input mem_pkg::data_t got, input mem_pkg::data_t exp,
                            input string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic write_burst(input mem_pkg::idx_t base, input mem_pkg::len_t len,
                             input mem_pkg::strb_t strb, input bit rand_strb);
    mem_pkg::data_t d;
    mem_pkg::strb_t s;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= make_addr(base);
    awlen   <= len;
    do @(negedge clk); while (!awready);
    @(posedge clk);  // aw handshake
    awvalid <= 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      d = random_data();
      s = rand_strb ? mem_pkg::strb_t'($random(seed)) : strb;
      wvalid <= 1'b1;
      wdata  <= d;
      wstrb  <= s;
      wlast  <= (k == int'(len));
      do @(negedge clk); while (!wready);
      @(posedge clk);
      ref_write(mem_pkg::idx_t'(base + k), d, s);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
  endtask

  // every cycle with rvalid is checked, so stalled beats must hold
  task automatic read_burst(input mem_pkg::idx_t base, input mem_pkg::len_t len,
                            input bit gaps);
    mem_pkg::data_t exp;
    bit             taken;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= make_addr(base);
    arlen   <= len;
    do @(negedge clk); while (!arready);
    @(posedge clk);  // ar handshake
    arvalid <= 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      exp   = ref_beat(mem_pkg::idx_t'(base + k));
      taken = 1'b0;
      while (!taken) begin
        rready <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
        @(negedge clk);
        if (rvalid) begin
          check_data(rdata, exp, "read beat");
          check_flag(rlast, k == int'(len), "rlast");
          taken = rready;
        end
        @(posedge clk);
      end
    end
    rready <= 1'b0;
    @(negedge clk);
    check_flag(arready, 1'b1, "arready after last beat");
    check_flag(rvalid, 1'b0, "rvalid after last beat");
  endtask

  task automatic test_reset_values();
    @(negedge clk);
    check_flag(awready, 1'b1, "awready after reset");
    check_flag(wready, 1'b0, "wready after reset");
    check_flag(arready, 1'b1, "arready after reset");
    check_flag(rvalid, 1'b0, "rvalid after reset");
  endtask

  task automatic test_full_bursts();
    mem_pkg::idx_t base;
    for (int n = 0; n < 8; n++) begin
      base = mem_pkg::idx_t'($random(seed));
      write_burst(base, mem_pkg::len_t'(n), '1, 1'b0);
      read_burst(base, mem_pkg::len_t'(n), 1'b0);
    end
  endtask

  task automatic test_strobe_merge();
    write_burst(8'd40, 8'd0, 32'h0000_ffff, 1'b0);  // low half
    write_burst(8'd40, 8'd0, 32'hffff_0000, 1'b0);  // high half
    read_burst(8'd40, 8'd0, 1'b0);
    write_burst(8'd60, 8'd3, '1, 1'b0);  // defined background first
    write_burst(8'd60, 8'd3, '0, 1'b1);
    read_burst(8'd60, 8'd3, 1'b0);
  endtask

  task automatic test_backpressure();
    write_burst(8'd120, 8'd7, '1, 1'b0);
    read_burst(8'd120, 8'd7, 1'b0);
    read_burst(8'd120, 8'd7, 1'b1);
    read_burst(8'd120, 8'd7, 1'b1);
  endtask

  task automatic test_overlap();
    write_burst(8'd200, 8'd7, '1, 1'b0);
    fork
      write_burst(8'd100, 8'd7, '1, 1'b0);
      read_burst(8'd200, 8'd7, 1'b1);
    join
    read_burst(8'd100, 8'd7, 1'b0);
  endtask

  task automatic test_wrap();
    write_burst(8'd254, 8'd3, '1, 1'b0);  // beats 254, 255, 0, 1
    read_burst(8'd0, 8'd1, 1'b0);
    read_burst(8'd254, 8'd3, 1'b0);
  endtask

  initial begin
    seed     = 54141;
    n_checks = 0;
    n_errors = 0;
    rst     <= 1'b1;
    awvalid <= 1'b0;
    awaddr  <= '0;
    awlen   <= '0;
    wvalid  <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wlast   <= 1'b0;
    arvalid <= 1'b0;
    araddr  <= '0;
    arlen   <= '0;
    rready  <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_reset_values();
    test_full_bursts();
    test_strobe_merge();
    test_backpressure();
    test_overlap();
    test_wrap();
    repeat (2) @(posedge clk);
    $display("checks: %0d  value errors: %0d  assertion failures: %0d",
             n_checks, n_errors, UUT.u_checks.fail_count);
    if (n_errors == 0 && UUT.u_checks.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog sized from test count, longest burst and stall allowance
  initial begin
    int num_tests;
    int max_beats;
    int stall_factor;
    num_tests    = 6;
    max_beats    = 8;
    stall_factor = 64;  // several bursts per test plus random stalls
    #(num_tests * max_beats * stall_factor * 4);
    $display("timeout: the tests did not complete, a handshake never arrived");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/axi_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave (
  input  wire logic           clk,
  input  wire logic           rst,
  // write address and data
  input  wire logic           awvalid,
  output logic                awready,
  input  wire mem_pkg::addr_t awaddr,
  input  wire mem_pkg::len_t  awlen,
  input  wire logic           wvalid,
  output logic                wready,
  input  wire mem_pkg::data_t wdata,
  input  wire mem_pkg::strb_t wstrb,
  input  wire logic           wlast,    // burst end comes from awlen
  // read address and data
  input  wire logic           arvalid,
  output logic                arready,
  input  wire mem_pkg::addr_t araddr,
  input  wire mem_pkg::len_t  arlen,
  output logic                rvalid,
  input  wire logic           rready,
  output mem_pkg::data_t      rdata,
  output logic                rlast
);

  // store write port
  logic           st_we;
  mem_pkg::idx_t  st_waddr;
  mem_pkg::strb_t st_wbe;
  mem_pkg::data_t st_wdata;

  // store read port
  logic           st_re;
  mem_pkg::idx_t  st_raddr;

  wr_channel u_wr (
    .clk       (clk),
    .rst       (rst),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .awready   (awready),
    .wready    (wready),
    .we        (st_we),
    .waddr     (st_waddr),
    .wbe       (st_wbe),
    .wdata_out (st_wdata)
  );

  rd_channel u_rd (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arlen   (arlen),
    .rready  (rready),
    .arready (arready),
    .rvalid  (rvalid),
    .rlast   (rlast),
    .re      (st_re),
    .raddr   (st_raddr)
  );

  line_store u_store (
    .clk   (clk),
    .we    (st_we),
    .waddr (st_waddr),
    .wbe   (st_wbe),
    .wdata (st_wdata),
    .re    (st_re),
    .raddr (st_raddr),
    .rdata (rdata)  // read register drives r data directly
  );

endmodule

`default_nettype wire

// File: src/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
  input  wire logic           clk,
  input  wire logic           we,
  input  wire mem_pkg::idx_t  waddr,
  input  wire mem_pkg::strb_t wbe,
  input  wire mem_pkg::data_t wdata,
  input  wire logic           re,
  input  wire mem_pkg::idx_t  raddr,
  output mem_pkg::data_t      rdata
);

  // beat array, contents undefined until written
  mem_pkg::data_t mem [mem_pkg::DEPTH_BEATS];

  // byte merge on write
  // only enabled lanes change, the rest keep old contents
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < mem_pkg::STRB_W; i++) begin
        if (wbe[i]) begin
          mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // registered read port
  // loads only on re so the output holds while r is stalled
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];  // old data on same-cycle write
    end
  end

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // bus and beat geometry
  localparam int DATA_W     = 256;
  localparam int STRB_W     = DATA_W / 8;  // one enable per byte
  localparam int ADDR_W     = 32;
  localparam int LEN_W      = 8;
  localparam int BEAT_SHIFT = 5;           // 32 bytes per beat

  // storage size, two beats per 64-byte cache line
  localparam int DEPTH_BEATS = 256;
  localparam int IDX_W       = 8;          // beat index, wraps at DEPTH_BEATS

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;       // beats minus one
  typedef logic [IDX_W-1:0]  idx_t;

  typedef enum logic {
    WR_IDLE,  // waiting on aw
    WR_DATA   // taking w beats
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,  // waiting on ar
    RD_SEND   // presenting beats on r
  } rd_state_e;

endpackage

`default_nettype wire

// File: src/rd_channel.sv
`timescale 1ns/1ps
`default_nettype none

module rd_channel (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           arvalid,
  input  wire mem_pkg::addr_t araddr,
  input  wire mem_pkg::len_t  arlen,
  input  wire logic           rready,
  output logic                arready,
  output logic                rvalid,
  output logic                rlast,
  output logic                re,
  output mem_pkg::idx_t       raddr
);

  mem_pkg::rd_state_e state;
  mem_pkg::idx_t      rd_idx;   // index of the beat now on r
  mem_pkg::len_t      rd_left;  // beats still to come after this one

  logic          ar_hs;
  logic          r_hs;
  mem_pkg::idx_t ar_idx;

  assign arready = (state == mem_pkg::RD_IDLE);
  assign rvalid  = (state == mem_pkg::RD_SEND);

  assign ar_hs  = arvalid & arready;
  assign r_hs   = rvalid & rready;
  assign ar_idx = araddr[mem_pkg::BEAT_SHIFT +: mem_pkg::IDX_W];

  // fetch control
  // first beat straight from araddr, later beats only when the current
  // one is taken and is not the last, so a stall never refetches
  always_comb begin
    if (state == mem_pkg::RD_IDLE) begin
      re    = ar_hs;
      raddr = ar_idx;
    end else begin
      re    = r_hs & ~rlast;
      raddr = rd_idx + 1'b1;  // wraps modulo depth
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= mem_pkg::RD_IDLE;
      rlast   <= 1'b0;
      rd_left <= '0;
    end else begin
      case (state)
        mem_pkg::RD_IDLE: begin
          if (ar_hs) begin
            state   <= mem_pkg::RD_SEND;
            rd_left <= arlen;
            rlast   <= (arlen == '0);  // single beat burst
          end
        end
        mem_pkg::RD_SEND: begin
          if (r_hs) begin
            if (rlast) begin
              state <= mem_pkg::RD_IDLE;
              rlast <= 1'b0;
            end else begin
              rd_left <= rd_left - 1'b1;
              rlast   <= (rd_left == 1);  // next beat is the final one
            end
          end
        end
        default: begin
          state <= mem_pkg::RD_IDLE;
          rlast <= 1'b0;
        end
      endcase
    end
  end

  // current beat index follows each fetch
  always_ff @(posedge clk) begin
    if (re) begin
      rd_idx <= raddr;
    end
  end

endmodule

`default_nettype wire

// File: src/wr_channel.sv
`timescale 1ns/1ps
`default_nettype none

module wr_channel (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           awvalid,
  input  wire mem_pkg::addr_t awaddr,
  input  wire mem_pkg::len_t  awlen,
  input  wire logic           wvalid,
  input  wire mem_pkg::data_t wdata,
  input  wire mem_pkg::strb_t wstrb,
  output logic                awready,
  output logic                wready,
  output logic                we,
  output mem_pkg::idx_t       waddr,
  output mem_pkg::strb_t      wbe,
  output mem_pkg::data_t      wdata_out
);

  mem_pkg::wr_state_e state;
  mem_pkg::idx_t      wr_idx;   // beat index of the next w beat
  mem_pkg::len_t      wr_len;   // captured awlen
  mem_pkg::len_t      wr_cnt;   // beats accepted so far

  logic aw_hs;
  logic w_hs;
  logic last_beat;

  // one burst at a time, aw and w never ready together
  assign awready = (state == mem_pkg::WR_IDLE);
  assign wready  = (state == mem_pkg::WR_DATA);

  assign aw_hs     = awvalid & awready;
  assign w_hs      = wvalid & wready;
  assign last_beat = (wr_cnt == wr_len);  // count decides the end, not wlast

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= mem_pkg::WR_IDLE;
      wr_cnt <= '0;
    end else begin
      case (state)
        mem_pkg::WR_IDLE: begin
          if (aw_hs) begin
            state  <= mem_pkg::WR_DATA;
            wr_cnt <= '0;
          end
        end
        mem_pkg::WR_DATA: begin
          if (w_hs) begin
            if (last_beat) begin
              state <= mem_pkg::WR_IDLE;  // awready back next cycle
            end else begin
              wr_cnt <= wr_cnt + 1'b1;
            end
          end
        end
        default: state <= mem_pkg::WR_IDLE;
      endcase
    end
  end

  // burst address and length, loaded on aw
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_idx <= awaddr[mem_pkg::BEAT_SHIFT +: mem_pkg::IDX_W];  // low bits dropped
      wr_len <= awlen;
    end else if (w_hs) begin
      wr_idx <= wr_idx + 1'b1;  // wraps past the top beat
    end
  end

  // store write port, same edge as the w handshake
  assign we        = w_hs;
  assign waddr     = wr_idx;
  assign wbe       = wstrb;
  assign wdata_out = wdata;

endmodule

`default_nettype wire

// File: vlog.f
src/mem_pkg.sv
src/line_store.sv
src/wr_channel.sv
src/rd_channel.sv
src/axi_mem_slave.sv
bench/axi_mem_assertions.sv
bench/axi_mem_tb.sv
